/* run_sim.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f verilog.f --top-module tb_s16_main -o sim_s16

./obj_dir/sim_s16 | tee sim.log

if grep -qx "tests failed" sim.log; then
    exit 1
fi
grep -qx "all tests passed" sim.log

/* s16_addr_decode.sv */
`timescale 1ns/1ns

module s16_addr_decode import s16_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cpu_bus_t    bus,
    output mem_region_t region,
    output logic        berr_n
);

    logic        as_seen;  // AS was already low on the previous edge
    mem_region_t map_region;
    logic [1:0]  a_hi;
    logic [2:0]  a_mid;

    assign a_hi  = bus.addr[23:22];
    assign a_mid = bus.addr[18:16];

    // System 16A memory map
    always_comb begin
        map_region = region_none;
        case (a_hi)
            2'd0: if (!a_mid[2]) map_region = region_rom;        // 00-03
            2'd1: begin
                case (a_mid)
                    3'd0: map_region = region_vram;              // 40
                    3'd1: map_region = region_char;              // 41
                    3'd4: map_region = region_obj;               // 44
                    default: map_region = region_none;
                endcase
            end
            2'd2: if (a_mid == 3'd4) map_region = region_pal;    // 84
            2'd3: begin
                case (a_mid)
                    3'd4: map_region = region_io;                // c4
                    3'd6: map_region = region_wdog;              // c6
                    3'd7: map_region = region_ram;               // c7
                    default: map_region = region_none;
                endcase
            end
            default: map_region = region_none;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            as_seen <= 1'b0;
            region  <= region_none;
            berr_n  <= 1'b1;
        end else begin
            as_seen <= !bus.as_n;
            if (!bus.as_n && as_seen) begin
                region <= map_region;
                berr_n <= map_region != region_none;
            end else begin
                region <= region_none;  // Released with AS
                berr_n <= 1'b1;
            end
        end
    end

    // Bus error only inside a running cycle and never with a chip select
    a_berr_valid: assert property (@(posedge clk) disable iff (rst)
        !berr_n |-> region == region_none && !$past(bus.as_n));

endmodule

/* s16_cab_io.sv */
`timescale 1ns/1ns

module s16_cab_io import s16_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cpu_bus_t   bus,
    input  logic       io_cs,
    input  cab_in_t    cab,
    output logic [7:0] cab_dout,
    output logic [7:0] snd_latch,
    output logic       flip,
    output logic       snd_irqn
);

    io_port_t   page;
    logic [1:0] port;
    logic       latch_we;
    logic       snd_irq;  // Inverse of the written bit 6

    // Joystick wiring of the board
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        sort_joy = {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    assign page     = io_port_t'(bus.addr[13:12]);
    assign port     = bus.addr[2:1];
    assign latch_we = io_cs && !bus.rnw && !bus.lds_n && page == io_latch;
    assign snd_irqn = !snd_irq;

    // Stand-in for the 8255 output ports
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_latch <= 8'h00;
            flip      <= 1'b0;
            snd_irq   <= 1'b0;
        end else if (latch_we) begin
            case (port)
                2'd0: snd_latch <= bus.dout[7:0];
                2'd1: begin
                    flip    <= bus.dout[7];
                    snd_irq <= !bus.dout[6];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        cab_dout = 8'hff;
        if (io_cs) begin
            case (page)
                io_latch: begin
                    case (port)
                        2'd0:    cab_dout = snd_latch;
                        2'd1:    cab_dout = {flip, snd_irqn, 6'h3f};
                        2'd2:    cab_dout = {1'b1, cab.snd_ack, 6'h3f};  // Status
                        default: cab_dout = 8'hff;
                    endcase
                end
                io_inputs: begin
                    case (port)
                        2'd0:    cab_dout = {2'b11, cab.start, cab.service, 1'b1, cab.coin};
                        2'd1:    cab_dout = sort_joy(cab.joy1);
                        2'd3:    cab_dout = sort_joy(cab.joy2);
                        default: cab_dout = 8'hff;
                    endcase
                end
                io_dips: cab_dout = bus.addr[1] ? cab.dipsw_b : cab.dipsw_a;
                default: cab_dout = 8'hff;
            endcase
        end
    end

endmodule

/* s16_dtack.sv */
`timescale 1ns/1ns

module s16_dtack import s16_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        as_n,
    input  mem_region_t region,
    input  logic        rom_ok,
    input  logic        ram_ok,
    output logic        dtack_n
);

    logic ready;

    // SDRAM backed areas wait for their ok flag
    always_comb begin
        case (region)
            region_none:  ready = 1'b0;
            region_rom:   ready = rom_ok;
            region_ram,
            region_vram:  ready = ram_ok;
            default:      ready = 1'b1;  // Internal RAMs and I/O
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtack_n <= 1'b1;
        end else begin
            if (as_n) begin
                dtack_n <= 1'b1;
            end else if (ready) begin
                dtack_n <= 1'b0;  // Held until AS rises
            end
        end
    end

    // One edge of release is allowed after AS goes high
    a_dtack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        as_n && $past(as_n) |-> dtack_n);

endmodule

/* s16_main_bus.sv */
`timescale 1ns/1ns
`include "s16_params.svh"

module s16_main_bus import s16_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  cpu_bus_t                   bus,
    input  cab_in_t                    cab,
    input  logic [15:0]                rom_data,
    input  logic [15:0]                ram_data,   // RAM or VRAM
    input  logic [15:0]                char_dout,
    input  logic [15:0]                pal_dout,
    input  logic [15:0]                obj_dout,
    input  logic                       rom_ok,
    input  logic                       ram_ok,
    input  logic [8:0]                 vdump,
    input  logic                       hstart,
    output logic [15:0]                cpu_din,
    output logic                       dtack_n,
    output logic                       berr_n,
    output logic                       irq_n,
    output logic                       rom_cs,
    output logic                       ram_cs,
    output logic                       vram_cs,
    output logic                       char_cs,
    output logic                       pal_cs,
    output logic                       objram_cs,
    output logic [`S16_ROM_ADDR_W-1:0] rom_addr,
    output logic [`S16_CPU_ADDR_W-1:0] cpu_addr,
    output logic [7:0]                 snd_latch,
    output logic                       flip,
    output logic                       snd_irqn
);

    mem_region_t region;
    logic        io_cs;
    logic [7:0]  cab_dout;

    assign rom_addr = bus.addr[17:1];
    assign cpu_addr = bus.addr[12:1];

    // One-hot selects from the registered region
    assign rom_cs    = region == region_rom;
    assign ram_cs    = region == region_ram;
    assign vram_cs   = region == region_vram;
    assign char_cs   = region == region_char;
    assign pal_cs    = region == region_pal;
    assign objram_cs = region == region_obj;
    assign io_cs     = region == region_io;

    s16_addr_decode i_addr_decode (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus),
        .region (region),
        .berr_n (berr_n)
    );

    s16_dtack i_dtack (
        .clk     (clk),
        .rst     (rst),
        .as_n    (bus.as_n),
        .region  (region),
        .rom_ok  (rom_ok),
        .ram_ok  (ram_ok),
        .dtack_n (dtack_n)
    );

    s16_cab_io i_cab_io (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .io_cs     (io_cs),
        .cab       (cab),
        .cab_dout  (cab_dout),
        .snd_latch (snd_latch),
        .flip      (flip),
        .snd_irqn  (snd_irqn)
    );

    s16_vblank_irq i_vblank_irq (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus),
        .vdump  (vdump),
        .hstart (hstart),
        .irq_n  (irq_n)
    );

    // Sampled every edge so a late ok flag still lands with DTACK
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= `S16_OPEN_BUS;
        end else begin
            if (ram_cs || vram_cs) cpu_din <= ram_data;
            else if (rom_cs)       cpu_din <= rom_data;
            else if (char_cs)      cpu_din <= char_dout;
            else if (pal_cs)       cpu_din <= pal_dout;
            else if (objram_cs)    cpu_din <= obj_dout;
            else if (io_cs)        cpu_din <= {8'hff, cab_dout};  // 8-bit port on D7:0
            else                   cpu_din <= `S16_OPEN_BUS;
        end
    end

endmodule

/* s16_params.svh */
`ifndef S16_PARAMS_SVH
`define S16_PARAMS_SVH

// Line where the VBLANK interrupt is raised
`define S16_VBLANK_LINE 9'd223

// Value seen when reading unmapped space
`define S16_OPEN_BUS 16'hffff

// Interrupt acknowledge function code
`define S16_FC_IACK 3'b111

// Address widths handed to the video RAMs and the ROM
`define S16_CPU_ADDR_W 12
`define S16_ROM_ADDR_W 17

`endif

/* s16_pkg.sv */
package s16_pkg;

    // One 68000 request as seen on the main bus
    typedef struct packed {
        logic [23:1] addr;  // Word address, byte lanes come from the strobes
        logic        as_n;
        logic        rnw;
        logic        uds_n;
        logic        lds_n;
        logic [2:0]  fc;    // Function code
        logic [15:0] dout;  // CPU write data
    } cpu_bus_t;

    // Decoded area of the System 16A map
    typedef enum logic [3:0] {
        region_none,
        region_rom,
        region_vram,
        region_char,
        region_obj,
        region_pal,
        region_io,
        region_wdog,
        region_ram
    } mem_region_t;

    // Cabinet side, inputs arrive active low
    typedef struct packed {
        logic [7:0] joy1;
        logic [7:0] joy2;
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
        logic       snd_ack;
        logic       dip_test;  // Kept for service mode
    } cab_in_t;

    // I/O page from A13:12
    typedef enum logic [1:0] {
        io_latch,
        io_inputs,
        io_dips,
        io_unused
    } io_port_t;

endpackage

/* s16_vblank_irq.sv */
`timescale 1ns/1ns
`include "s16_params.svh"

module s16_vblank_irq import s16_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cpu_bus_t   bus,
    input  logic [8:0] vdump,
    input  logic       hstart,
    output logic       irq_n
);

    logic last_hstart;
    logic iack;
    logic vb_start;

    assign iack     = bus.fc == `S16_FC_IACK && !bus.as_n;  // Level 4 acknowledge
    assign vb_start = hstart && !last_hstart && vdump == `S16_VBLANK_LINE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_hstart <= 1'b0;
            irq_n       <= 1'b1;
        end else begin
            last_hstart <= hstart;
            if (iack) begin
                irq_n <= 1'b1;  // Acknowledge wins
            end else if (vb_start) begin
                irq_n <= 1'b0;
            end
        end
    end

    a_no_fall_on_iack: assert property (@(posedge clk) disable iff (rst)
        $fell(irq_n) |-> !$past(iack));

endmodule

/* tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = !clk;  // 100 ns period
    end

    // Reset over the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;
    end

endmodule

/* tb_s16_main.sv */
`timescale 1ns/1ns
`include "s16_params.svh"

module tb_s16_main import s16_pkg::*; ();

    // Expected selects as {rom, ram, vram, char, pal, obj}
    localparam logic [5:0]  CS_NONE = 6'b000000;
    localparam logic [5:0]  CS_ROM  = 6'b100000;
    localparam logic [5:0]  CS_RAM  = 6'b010000;
    localparam logic [5:0]  CS_VRAM = 6'b001000;
    localparam logic [5:0]  CS_CHAR = 6'b000100;
    localparam logic [5:0]  CS_PAL  = 6'b000010;
    localparam logic [5:0]  CS_OBJ  = 6'b000001;
    localparam logic [15:0] CHAR_WORD = 16'h1c3d;
    localparam logic [15:0] PAL_WORD  = 16'h5e7f;
    localparam logic [15:0] OBJ_WORD  = 16'h9ab0;
    localparam logic [2:0]  FC_DATA = 3'b101;  // Supervisor data
    localparam logic [2:0]  FC_IACK = 3'b111;

    typedef struct packed {
        logic [23:0] baddr;    // Byte address
        logic        rnw;
        logic [15:0] wdata;
        logic [2:0]  fc;
        logic [7:0]  rom_dly;  // Edges with rom_ok low
        logic [7:0]  ram_dly;
        logic [5:0]  cs;
        logic        berr;
        logic [15:0] rdata;    // Used when no ROM or RAM select is expected
    } row_t;

    logic clk, rst;
    cpu_bus_t bus;
    cab_in_t cab;
    logic [15:0] rom_data, ram_data, char_dout, pal_dout, obj_dout, cpu_din;
    logic rom_ok, ram_ok, hstart;
    logic [8:0] vdump;
    logic dtack_n, berr_n, irq_n, flip, snd_irqn;
    logic rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs;
    logic [`S16_ROM_ADDR_W-1:0] rom_addr;
    logic [`S16_CPU_ADDR_W-1:0] cpu_addr;
    logic [7:0] snd_latch;
    logic [5:0] cs_vec;
    logic [31:0] lfsr;
    row_t table_q[$];
    int cycles;
    int timeout_cycles;
    logic [7:0] model_latch;
    logic model_flip, model_irqn;

    assign cs_vec = {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs};

    tb_clock i_clock (
        .clk (clk),
        .rst (rst)
    );

    s16_main_bus i_s16_main_bus (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic add_row(input logic [23:0] baddr, input logic rnw, input logic [15:0] wdata,
                           input logic [7:0] rom_dly, input logic [7:0] ram_dly,
                           input logic [5:0] cs, input logic berr, input logic [15:0] rdata);
        row_t r;
        r = '{baddr, rnw, wdata, FC_DATA, rom_dly, ram_dly, cs, berr, rdata};
        table_q.push_back(r);
    endtask

    // One full 68000 cycle with AS held until DTACK or BERR
    task automatic run_row(input row_t r);
        logic [7:0]  e;
        logic [7:0]  d;
        logic [7:0]  exp_edge;
        logic [15:0] exp_word;
        logic        done;
        take_bits(16, rom_data);
        take_bits(16, ram_data);
        bus.addr  = r.baddr[23:1];
        bus.rnw   = r.rnw;
        bus.uds_n = !r.rnw;  // Writes go to D7:0 only
        bus.lds_n = 1'b0;
        bus.fc    = r.fc;
        bus.dout  = r.wdata;
        rom_ok    = r.rom_dly == 8'd0;
        ram_ok    = r.ram_dly == 8'd0;
        bus.as_n  = 1'b0;
        e = 8'd0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            #10;
            if (e == 8'd0 && r.fc == FC_IACK) compare("irq_n", 32'(irq_n), 32'd1);
            if (e == 8'd1) begin
                compare("chip_selects", 32'(cs_vec), 32'(r.cs));
                compare("berr_n", 32'(berr_n), 32'(!r.berr));
                compare("rom_addr", 32'(rom_addr), 32'(r.baddr[17:1]));
                compare("cpu_addr", 32'(cpu_addr), 32'(r.baddr[12:1]));
            end
            if (!dtack_n || !berr_n) begin
                done = 1'b1;
            end else begin
                if (e == r.rom_dly) begin
                    rom_ok = 1'b1;  // Flag rises after edge N
                    take_bits(16, rom_data);  // Fresh word arrives with the flag
                end
                if (e == r.ram_dly) begin
                    ram_ok = 1'b1;
                    take_bits(16, ram_data);
                end
                e++;
            end
        end
        d = 8'd0;
        if (r.cs == CS_ROM) d = r.rom_dly;
        else if (r.cs == CS_RAM || r.cs == CS_VRAM) d = r.ram_dly;
        exp_edge = r.berr ? 8'd1 : ((d + 8'd1 > 8'd2) ? d + 8'd1 : 8'd2);
        compare("end_edge", 32'(e), 32'(exp_edge));
        if (r.rnw) begin
            exp_word = r.rdata;
            if (r.cs == CS_ROM) exp_word = rom_data;
            else if (r.cs == CS_RAM || r.cs == CS_VRAM) exp_word = ram_data;
            compare("cpu_din", 32'(cpu_din), 32'(exp_word));
        end
        bus.as_n = 1'b1;
        rom_ok = 1'b1;
        ram_ok = 1'b1;
        @(posedge clk);
        #10;
        compare("dtack_n", 32'(dtack_n), 32'd1);
        compare("berr_n", 32'(berr_n), 32'd1);
        compare("chip_selects", 32'(cs_vec), 32'(CS_NONE));
        if (!r.rnw && r.baddr == 24'hc40000) model_latch = r.wdata[7:0];
        if (!r.rnw && r.baddr == 24'hc40002) begin
            model_flip = r.wdata[7];
            model_irqn = r.wdata[6];
        end
        compare("snd_latch", 32'(snd_latch), 32'(model_latch));
        compare("flip", 32'(flip), 32'(model_flip));
        compare("snd_irqn", 32'(snd_irqn), 32'(model_irqn));
    endtask

    task automatic pulse_hstart(input logic [8:0] line, input logic exp_irq);
        vdump  = line;
        hstart = 1'b1;
        @(posedge clk);
        #10;
        compare("irq_n", 32'(irq_n), 32'(exp_irq));
        hstart = 1'b0;
        @(posedge clk);
        #10;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (timeout_cycles != 0 && cycles > timeout_cycles) begin
            $display("Timeout: the bus did not answer within %0d cycles", timeout_cycles);
            $display("tests failed");
            $fatal(1);
        end
    end

    initial begin
        row_t       ack_row;
        logic [7:0] max_dly;
        lfsr = 32'hd42593e1;
        bus = '0;
        bus.as_n = 1'b1;
        bus.rnw = 1'b1;
        bus.uds_n = 1'b1;
        bus.lds_n = 1'b1;
        cab = '{joy1: 8'hfe, joy2: 8'hef, start: 2'b10, coin: 2'b01, service: 1'b0,
                dipsw_a: 8'h3c, dipsw_b: 8'ha5, snd_ack: 1'b0, dip_test: 1'b1};
        rom_data = '0;
        ram_data = '0;
        char_dout = CHAR_WORD;
        pal_dout = PAL_WORD;
        obj_dout = OBJ_WORD;
        rom_ok = 1'b1;
        ram_ok = 1'b1;
        vdump = 9'd0;
        hstart = 1'b0;
        model_latch = 8'h00;
        model_flip = 1'b0;
        model_irqn = 1'b1;

        add_row(24'h000124, 1'b1, 16'h0000, 8'd0, 8'd0, CS_ROM, 1'b0, 16'h0000);
        add_row(24'h01fffe, 1'b1, 16'h0000, 8'd3, 8'd0, CS_ROM, 1'b0, 16'h0000);
        add_row(24'h030010, 1'b1, 16'h0000, 8'd5, 8'd0, CS_ROM, 1'b0, 16'h0000);
        add_row(24'h400200, 1'b1, 16'h0000, 8'd0, 8'd0, CS_VRAM, 1'b0, 16'h0000);
        add_row(24'h400202, 1'b1, 16'h0000, 8'd0, 8'd4, CS_VRAM, 1'b0, 16'h0000);
        add_row(24'h410040, 1'b1, 16'h0000, 8'd0, 8'd0, CS_CHAR, 1'b0, CHAR_WORD);
        add_row(24'h440010, 1'b1, 16'h0000, 8'd0, 8'd0, CS_OBJ, 1'b0, OBJ_WORD);
        add_row(24'h840020, 1'b1, 16'h0000, 8'd0, 8'd0, CS_PAL, 1'b0, PAL_WORD);
        add_row(24'hc70100, 1'b1, 16'h0000, 8'd0, 8'd0, CS_RAM, 1'b0, 16'h0000);
        add_row(24'hc7fffe, 1'b1, 16'h0000, 8'd0, 8'd2, CS_RAM, 1'b0, 16'h0000);
        add_row(24'hc60000, 1'b1, 16'h0000, 8'd0, 8'd0, CS_NONE, 1'b0, `S16_OPEN_BUS);
        add_row(24'h040000, 1'b1, 16'h0000, 8'd0, 8'd0, CS_NONE, 1'b1, `S16_OPEN_BUS);
        add_row(24'h800000, 1'b1, 16'h0000, 8'd0, 8'd0, CS_NONE, 1'b1, `S16_OPEN_BUS);
        add_row(24'hc50000, 1'b1, 16'h0000, 8'd0, 8'd0, CS_NONE, 1'b1, `S16_OPEN_BUS);
        // Cabinet ports with the high byte always ff
        add_row(24'hc41000, 1'b1, 16'h0000, 8'd0, 8'd0, CS_NONE, 1'b0, 16'hffe5);
        add_row(24'hc41002, 1'b1, 16'h0000, 8'd0, 8'd0, CS_NONE, 1'b0, 16'hffbf);
        add_row(24'hc41006, 1'b1, 16'h0000, 8'd0, 8'd0, CS_NONE, 1'b0, 16'hfffd);
        add_row(24'hc42000, 1'b1, 16'h0000, 8'd0, 8'd0, CS_NONE, 1'b0, 16'hff3c);
        add_row(24'hc42002, 1'b1, 16'h0000, 8'd0, 8'd0, CS_NONE, 1'b0, 16'hffa5);
        add_row(24'hc40000, 1'b0, 16'h005a, 8'd0, 8'd0, CS_NONE, 1'b0, 16'h0000);
        add_row(24'hc40000, 1'b1, 16'h0000, 8'd0, 8'd0, CS_NONE, 1'b0, 16'hff5a);
        add_row(24'hc40002, 1'b0, 16'h0080, 8'd0, 8'd0, CS_NONE, 1'b0, 16'h0000);
        add_row(24'hc40002, 1'b1, 16'h0000, 8'd0, 8'd0, CS_NONE, 1'b0, 16'hffbf);
        add_row(24'hc40002, 1'b0, 16'h0040, 8'd0, 8'd0, CS_NONE, 1'b0, 16'h0000);
        add_row(24'hc40002, 1'b1, 16'h0000, 8'd0, 8'd0, CS_NONE, 1'b0, 16'hff7f);
        add_row(24'hc40004, 1'b1, 16'h0000, 8'd0, 8'd0, CS_NONE, 1'b0, 16'hffbf);
        add_row(24'hc40006, 1'b1, 16'h0000, 8'd0, 8'd0, CS_NONE, 1'b0, 16'hffff);

        max_dly = 8'd0;
        foreach (table_q[i]) begin
            if (table_q[i].rom_dly > max_dly) max_dly = table_q[i].rom_dly;
            if (table_q[i].ram_dly > max_dly) max_dly = table_q[i].ram_dly;
        end
        timeout_cycles = table_q.size() * (int'(max_dly) + 4) + 40;

        @(negedge rst);
        @(posedge clk);
        #10;
        compare("dtack_n", 32'(dtack_n), 32'd1);
        compare("berr_n", 32'(berr_n), 32'd1);
        compare("irq_n", 32'(irq_n), 32'd1);
        compare("chip_selects", 32'(cs_vec), 32'(CS_NONE));
        compare("cpu_din", 32'(cpu_din), 32'(`S16_OPEN_BUS));
        compare("snd_latch", 32'(snd_latch), 32'd0);
        compare("flip", 32'(flip), 32'd0);
        compare("snd_irqn", 32'(snd_irqn), 32'd1);

        foreach (table_q[i]) run_row(table_q[i]);

        // VBLANK request held across later lines and then acknowledged
        pulse_hstart(9'd100, 1'b1);
        pulse_hstart(`S16_VBLANK_LINE, 1'b0);
        pulse_hstart(`S16_VBLANK_LINE + 9'd1, 1'b0);
        ack_row = '{24'hfffff8, 1'b1, 16'h0000, FC_IACK, 8'd0, 8'd0, CS_RAM, 1'b0, 16'h0000};
        run_row(ack_row);
        compare("irq_n", 32'(irq_n), 32'd1);

        $display("all tests passed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
s16_pkg.sv
s16_addr_decode.sv
s16_dtack.sv
s16_cab_io.sv
s16_vblank_irq.sv
s16_main_bus.sv
tb_clock.sv
tb_s16_main.sv
